// File: design/fpFormatPkg.sv
// IEEE 754 single-precision format definitions for the multiplier core
// Word layout, a raw/field view of an operand and the format constants
// Imported by the pipeline package, the stages, the top level and the testbench

package fpFormatPkg;

    // ====================
    // Field widths
    // ====================
    localparam int ExpW  = 8;
    localparam int FracW = 23;

    // Significand width including the hidden bit
    localparam int SigW = FracW + 1;

    // ====================
    // Format constants
    // ====================
    localparam int ExpBias = 127;

    // All-ones exponent, marks Inf and NaN
    localparam int ExpMax = 255;

    // Canonical quiet NaN, positive sign, payload MSB only
    localparam logic [31:0] QuietNan = 32'h7FC0_0000;

    // ====================
    // Word types
    // ====================

    // Single-precision word, sign in bit 31
    typedef struct packed {
        logic             sign;
        logic [ExpW-1:0]  exp;
        logic [FracW-1:0] frac;
    } fp32T;

    // Same 32 bits seen either as a plain word or as fields
    typedef union packed {
        logic [31:0] raw;
        fp32T        f;
    } fpWordU;

endpackage

// File: design/fpMulPipePkg.sv
// Pipeline records and status types of the floating-point multiplier
// Operand class, result flags and the stage-to-stage records
// Each record carries its own valid bit alongside the data

package fpMulPipePkg;

    import fpFormatPkg::*;

    // Exponent sum width, signed, covers -127 up to 383
    localparam int ExpSumW = 10;

    // ====================
    // Operand class
    // ====================

    // Subnormals are flushed and decode as Zero
    typedef enum logic [1:0] {
        Zero   = 2'd0,
        Normal = 2'd1,
        Inf    = 2'd2,
        Nan    = 2'd3
    } fpClassE;

    // Status flags returned with each result
    typedef struct packed {
        logic overflow;
        logic underflow;
        logic invalid;
    } fpFlagsT;

    // ====================
    // Stage records
    // ====================

    // Decode to execute
    typedef struct packed {
        logic                       valid;
        logic                       sign;
        logic signed [ExpSumW-1:0]  expSum;
        fpClassE                    classA;
        fpClassE                    classB;
        logic [SigW-1:0]            sigA;
        logic [SigW-1:0]            sigB;
    } decodedOpT;

    // Execute to result, full significand product
    typedef struct packed {
        logic                       valid;
        logic                       sign;
        logic signed [ExpSumW-1:0]  expSum;
        fpClassE                    classA;
        fpClassE                    classB;
        logic [2*SigW-1:0]          prod;
    } productT;

endpackage

// File: design/fpOperandDecode.sv
// Decode stage of the floating-point multiplier
// Splits both operands into fields, classifies them and forms the
// product sign and the biased exponent sum, then registers the record
// One cycle from inValid_i to dec_o

`timescale 1ns/100ps

module fpOperandDecode
    import fpFormatPkg::*;
    import fpMulPipePkg::*;
(
    input  logic      clk,
    input  logic      arstN_i,
    input  logic      inValid_i,
    input  fp32T      opA_i,
    input  fp32T      opB_i,
    output decodedOpT dec_o
);

    fpWordU    wordA;
    fpWordU    wordB;
    fpClassE   classA;
    fpClassE   classB;
    decodedOpT decNext;
    decodedOpT decQ;
    logic      validQ;

    // Zero exponent covers true zero and flushed subnormals
    function automatic fpClassE classify(input fp32T f);
        if (f.exp == '0) begin
            return Zero;
        end else if (f.exp == ExpW'(ExpMax)) begin
            return (f.frac == '0) ? Inf : Nan;
        end
        return Normal;
    endfunction

    // Operands enter as plain words
    assign wordA.raw = opA_i;
    assign wordB.raw = opB_i;

    assign classA = classify(wordA.f);
    assign classB = classify(wordB.f);

    always_comb begin
        decNext.valid  = inValid_i;
        decNext.sign   = wordA.f.sign ^ wordB.f.sign;
        // Biased sum, one bias removed
        decNext.expSum = ExpSumW'(int'(wordA.f.exp) + int'(wordB.f.exp) - ExpBias);
        decNext.classA = classA;
        decNext.classB = classB;
        // Hidden bit only for normal numbers
        decNext.sigA   = {classA == Normal, wordA.f.frac};
        decNext.sigB   = {classB == Normal, wordB.f.frac};
    end

    // Valid strobe
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid_i;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        decQ <= decNext;
    end

    always_comb begin
        dec_o       = decQ;
        dec_o.valid = validQ;
    end

endmodule

// File: design/koaCombMult.sv
// Recursive combinational Karatsuba-Ofman multiplier
// Splits the operands in two halves and builds the product from three
// narrower products of the same kind, down to a plain product at LeafW
// Unsigned operands, full-width 2W-bit product

`timescale 1ns/100ps

module koaCombMult #(
    parameter int W     = 24,
    parameter int LeafW = 6
) (
    input  logic [W-1:0]   a_i,
    input  logic [W-1:0]   b_i,
    output logic [2*W-1:0] p_o
);

    // Below 4 bits the middle operand is no narrower than W
    localparam bit IsLeaf = (W <= LeafW) || (W < 4);

    generate
        if (IsLeaf) begin : gLeaf

            assign p_o = a_i * b_i;

        end else begin : gSplit

            // Wider half goes to the low side on odd widths
            localparam int LoW  = W - W / 2;
            localparam int HiW  = W / 2;
            localparam int MidW = LoW + 1;

            logic [MidW-1:0]   sumA;
            logic [MidW-1:0]   sumB;
            logic [2*HiW-1:0]  pHi;
            logic [2*LoW-1:0]  pLo;
            logic [2*MidW-1:0] pMid;
            logic [2*MidW-1:0] midTerm;
            logic [2*W-1:0]    hiPart;
            logic [2*W-1:0]    midPart;
            logic [2*W-1:0]    loPart;

            // Half sums, one bit wider
            assign sumA = MidW'(a_i[W-1:LoW]) + MidW'(a_i[LoW-1:0]);
            assign sumB = MidW'(b_i[W-1:LoW]) + MidW'(b_i[LoW-1:0]);

            koaCombMult #(
                .W     (HiW),
                .LeafW (LeafW)
            ) hiMult (
                .a_i (a_i[W-1:LoW]),
                .b_i (b_i[W-1:LoW]),
                .p_o (pHi)
            );

            koaCombMult #(
                .W     (LoW),
                .LeafW (LeafW)
            ) loMult (
                .a_i (a_i[LoW-1:0]),
                .b_i (b_i[LoW-1:0]),
                .p_o (pLo)
            );

            koaCombMult #(
                .W     (MidW),
                .LeafW (LeafW)
            ) midMult (
                .a_i (sumA),
                .b_i (sumB),
                .p_o (pMid)
            );

            // Cross terms aHi*bLo + aLo*bHi
            assign midTerm = pMid - pHi - pLo;

            // Recombine at 2*LoW, LoW and 0
            assign hiPart  = {pHi, {(2 * LoW){1'b0}}};
            assign midPart = (2 * W)'(midTerm) << LoW;
            assign loPart  = (2 * W)'(pLo);

            assign p_o = hiPart + midPart + loPart;

        end
    endgenerate

endmodule

// File: design/koaSignificandMult.sv
// Execute stage of the floating-point multiplier
// Registers the decoded record, then forms the 48-bit significand product
// as one Karatsuba level over three recursive combinational multipliers
// Class, sign and exponent fields travel alongside unchanged

`timescale 1ns/100ps

module koaSignificandMult
    import fpFormatPkg::*;
    import fpMulPipePkg::*;
#(
    parameter int LeafW = 6
) (
    input  logic      clk,
    input  logic      arstN_i,
    input  decodedOpT dec_i,
    output productT   prod_o
);

    localparam int HalfW = SigW / 2;

    decodedOpT             decQ;
    logic                  validQ;
    logic [HalfW:0]        sumA;
    logic [HalfW:0]        sumB;
    logic [2*HalfW-1:0]    qLeft;
    logic [2*HalfW-1:0]    qRight;
    logic [2*HalfW+1:0]    qMiddle;
    logic [2*HalfW+1:0]    midTerm;
    logic [2*SigW-1:0]     product;

    // ====================
    // Segmentation register
    // ====================
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        decQ <= dec_i;
    end

    // ====================
    // Karatsuba level
    // ====================

    // Upper halves
    koaCombMult #(
        .W     (HalfW),
        .LeafW (LeafW)
    ) left (
        .a_i (decQ.sigA[SigW-1:HalfW]),
        .b_i (decQ.sigB[SigW-1:HalfW]),
        .p_o (qLeft)
    );

    // Lower halves
    koaCombMult #(
        .W     (HalfW),
        .LeafW (LeafW)
    ) right (
        .a_i (decQ.sigA[HalfW-1:0]),
        .b_i (decQ.sigB[HalfW-1:0]),
        .p_o (qRight)
    );

    // Half sums carry one extra bit
    assign sumA = {1'b0, decQ.sigA[SigW-1:HalfW]} + {1'b0, decQ.sigA[HalfW-1:0]};
    assign sumB = {1'b0, decQ.sigB[SigW-1:HalfW]} + {1'b0, decQ.sigB[HalfW-1:0]};

    koaCombMult #(
        .W     (HalfW + 1),
        .LeafW (LeafW)
    ) middle (
        .a_i (sumA),
        .b_i (sumB),
        .p_o (qMiddle)
    );

    // Middle term minus the outer products
    assign midTerm = qMiddle - qLeft - qRight;

    // Outer products side by side, middle term shifted by one half
    assign product = {qLeft, qRight}
                   + {{(2 * SigW - 3 * HalfW - 2){1'b0}}, midTerm, {HalfW{1'b0}}};

    always_comb begin
        prod_o.valid  = validQ;
        prod_o.sign   = decQ.sign;
        prod_o.expSum = decQ.expSum;
        prod_o.classA = decQ.classA;
        prod_o.classB = decQ.classB;
        prod_o.prod   = product;
    end

endmodule

// File: design/fpResultPack.sv
// Result stage of the floating-point multiplier
// Normalizes and rounds the significand product to nearest-even,
// resolves special operands and range limits, registers result and flags
// Subnormal results flush to signed zero

`timescale 1ns/100ps

module fpResultPack
    import fpFormatPkg::*;
    import fpMulPipePkg::*;
(
    input  logic    clk,
    input  logic    arstN_i,
    input  productT prod_i,
    output logic    outValid_o,
    output fp32T    result_o,
    output fpFlagsT flags_o
);

    logic                      anyNan;
    logic                      anyInf;
    logic                      anyZero;
    logic [2*SigW-1:0]         normProd;
    logic signed [ExpSumW-1:0] expNorm;
    logic signed [ExpSumW-1:0] expFinal;
    logic                      guard;
    logic                      roundBit;
    logic                      sticky;
    logic                      roundUp;
    logic [FracW:0]            fracRounded;
    fp32T                      resultNext;
    fpFlagsT                   flagsNext;
    logic                      validQ;
    fp32T                      resultQ;
    fpFlagsT                   flagsQ;

    assign anyNan  = (prod_i.classA == Nan) || (prod_i.classB == Nan);
    assign anyInf  = (prod_i.classA == Inf) || (prod_i.classB == Inf);
    assign anyZero = (prod_i.classA == Zero) || (prod_i.classB == Zero);

    // ====================
    // Normalize and round
    // ====================

    // Leading one ends up in bit 47
    assign normProd = prod_i.prod[2*SigW-1] ? prod_i.prod : (prod_i.prod << 1);
    assign expNorm  = prod_i.expSum + $signed({{(ExpSumW - 1){1'b0}}, prod_i.prod[2*SigW-1]});

    assign guard    = normProd[SigW-1];
    assign roundBit = normProd[SigW-2];
    assign sticky   = |normProd[SigW-3:0];

    // Ties go to the even fraction
    assign roundUp = guard & (roundBit | sticky | normProd[SigW]);

    assign fracRounded = {1'b0, normProd[2*SigW-2:SigW]} + (FracW + 1)'(roundUp);

    // Carry out means 10.000..., the fraction field is already zero
    assign expFinal = expNorm + $signed({{(ExpSumW - 1){1'b0}}, fracRounded[FracW]});

    // ====================
    // Result selection
    // ====================
    always_comb begin
        flagsNext       = '0;
        resultNext.sign = prod_i.sign;
        resultNext.exp  = expFinal[ExpW-1:0];
        resultNext.frac = fracRounded[FracW-1:0];
        if (anyNan || (anyInf && anyZero)) begin
            resultNext        = QuietNan;
            flagsNext.invalid = 1'b1;
        end else if (anyInf) begin
            resultNext.exp  = '1;
            resultNext.frac = '0;
        end else if (anyZero) begin
            resultNext.exp  = '0;
            resultNext.frac = '0;
        end else if (expFinal >= ExpMax) begin
            // Past the largest finite exponent
            resultNext.exp     = '1;
            resultNext.frac    = '0;
            flagsNext.overflow = 1'b1;
        end else if (expFinal <= 0) begin
            resultNext.exp      = '0;
            resultNext.frac     = '0;
            flagsNext.underflow = 1'b1;
        end
    end

    // Output register
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= prod_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        resultQ <= resultNext;
        flagsQ  <= flagsNext;
    end

    assign outValid_o = validQ;
    assign result_o   = resultQ;
    assign flags_o    = flagsQ;

endmodule

// File: design/fpMulCore.sv
// Pipelined single-precision floating-point multiplier
// Decode, Karatsuba execute and result stages, one register each
// A strobe on inValid_i returns result and flags three cycles later
// No back-pressure, one item accepted every cycle

`timescale 1ns/100ps

module fpMulCore
    import fpFormatPkg::*;
    import fpMulPipePkg::*;
#(
    // Width at which the Karatsuba recursion stops
    parameter int LeafW = 6
) (
    input  logic    clk,
    input  logic    arstN_i,
    input  logic    inValid_i,
    input  fp32T    opA_i,
    input  fp32T    opB_i,
    output logic    outValid_o,
    output fp32T    result_o,
    output fpFlagsT flags_o
);

    decodedOpT decOp;
    productT   prodRec;

    fpOperandDecode decode_inst (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .inValid_i (inValid_i),
        .opA_i     (opA_i),
        .opB_i     (opB_i),
        .dec_o     (decOp)
    );

    koaSignificandMult #(
        .LeafW (LeafW)
    ) execute_inst (
        .clk     (clk),
        .arstN_i (arstN_i),
        .dec_i   (decOp),
        .prod_o  (prodRec)
    );

    fpResultPack result_inst (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .prod_i     (prodRec),
        .outValid_o (outValid_o),
        .result_o   (result_o),
        .flags_o    (flags_o)
    );

endmodule

// File: tb/fpMulRef.svh
// Reference model, random source and result checks for the multiplier testbench
// Included inside the testbench module body and uses its package imports
// Expected values follow IEEE 754 single precision with flush-to-zero
// and round-to-nearest-even only

`ifndef FP_MUL_REF_SVH
`define FP_MUL_REF_SVH

// ====================
// Random source
// ====================

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] galoisStep(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

// ====================
// Reference model
// ====================

// Expected word and flags for a * b
function automatic fp32T fpMulRef(input fp32T a, input fp32T b, output fpFlagsT flags);
    fp32T        res;
    logic [47:0] exact;
    logic [22:0] mant;
    logic [23:0] tail;
    int          expo;
    bit          zeroA;
    bit          zeroB;
    bit          infA;
    bit          infB;
    bit          nanA;
    bit          nanB;

    flags = '0;
    // Subnormals count as zero
    zeroA = (a.exp == 8'h00);
    zeroB = (b.exp == 8'h00);
    infA  = (a.exp == 8'hFF) && (a.frac == 23'h0);
    infB  = (b.exp == 8'hFF) && (b.frac == 23'h0);
    nanA  = (a.exp == 8'hFF) && (a.frac != 23'h0);
    nanB  = (b.exp == 8'hFF) && (b.frac != 23'h0);

    res.sign = a.sign ^ b.sign;
    res.exp  = 8'h00;
    res.frac = 23'h0;

    if (nanA || nanB || (infA && zeroB) || (zeroA && infB)) begin
        flags.invalid = 1'b1;
        return fp32T'(QuietNan);
    end
    if (infA || infB) begin
        res.exp = 8'hFF;
        return res;
    end
    if (zeroA || zeroB) begin
        return res;
    end

    // Exact significand product, value in [1, 4)
    exact = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
    expo  = int'(a.exp) + int'(b.exp) - ExpBias;
    if (exact[47]) begin
        expo = expo + 1;
    end else begin
        exact = exact << 1;
    end
    mant = exact[46:24];
    tail = exact[23:0];

    // Above half rounds up, exact half only when the fraction is odd
    if ((tail > 24'h80_0000) || ((tail == 24'h80_0000) && mant[0])) begin
        if (mant == '1) begin
            mant = '0;
            expo = expo + 1;
        end else begin
            mant = mant + 23'd1;
        end
    end

    if (expo >= ExpMax) begin
        flags.overflow = 1'b1;
        res.exp        = 8'hFF;
    end else if (expo <= 0) begin
        flags.underflow = 1'b1;
    end else begin
        res.exp  = expo[7:0];
        res.frac = mant;
    end
    return res;
endfunction

// ====================
// Checks
// ====================
task automatic compareResult(input string name, input fp32T expV, input fp32T actV);
    if (actV !== expV) begin
        abortRun($sformatf("** Error: %s result expected %h actual %h", name, expV, actV));
    end
endtask

// Flags print as overflow, underflow, invalid
task automatic compareFlags(input string name, input fpFlagsT expV, input fpFlagsT actV);
    if (actV !== expV) begin
        abortRun($sformatf("** Error: %s flags expected %b actual %b", name, expV, actV));
    end
endtask

`endif

// File: tb/fpMulCoreTb.sv
// Testbench for the pipelined floating-point multiplier
// Drives operand pairs on the falling edge, predicts each result with the
// reference model and checks every output strobe against a queue
// Covers random products, rounding ties, special operands, range limits,
// gaps between strobes and a reset in the middle of a stream

`timescale 1ns/100ps

module fpMulCoreTb
    import fpFormatPkg::*;
    import fpMulPipePkg::*;
;

    localparam int ResetCycles    = 16;
    localparam int MidResetCycles = 4;
    localparam int Latency        = 3;
    localparam int NumRandom      = 2000;
    localparam int NumRounding    = 5;
    localparam int NumSpecialVals = 12;
    localparam int NumRange       = 200;
    localparam int NumGap         = 200;
    localparam int NumFlush       = 2;
    localparam int MaxGap         = 3;
    localparam int Margin         = 100;

    localparam int NumItems = NumRandom + NumRounding + NumSpecialVals * NumSpecialVals
                            + 2 * NumRange + 2 * NumGap + NumFlush;

    // Every item, the worst-case gaps, both resets and the drain
    localparam int TimeoutCycles = ResetCycles + MidResetCycles + NumItems
                                 + 2 * NumGap * MaxGap + Latency + Margin;

    // Zero, infinity, NaN and subnormal of both signs, plus a few normals
    localparam logic [31:0] SpecialVals [NumSpecialVals] = '{
        32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
        32'h7FC0_0000, 32'h7F80_0001, 32'hFFC0_0001, 32'h0000_0001,
        32'h807F_FFFF, 32'h3F80_0000, 32'hC020_0000, 32'h7F7F_FFFF
    };

    logic    clk;
    logic    arstN_i;
    logic    inValid_i;
    fp32T    opA_i;
    fp32T    opB_i;
    logic    outValid_o;
    fp32T    result_o;
    fpFlagsT flags_o;

    int          cycleCount = 0;
    logic [31:0] lfsrState;

    // Expected items in strobe order
    string   nameQ[$];
    fp32T    expResultQ[$];
    fpFlagsT expFlagsQ[$];
    int      dueQ[$];

    // First failure ends the run
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "fpMulRef.svh"

    fpMulCore #(
        .LeafW (6)
    ) fpMulCore_inst (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .inValid_i  (inValid_i),
        .opA_i      (opA_i),
        .opB_i      (opB_i),
        .outValid_o (outValid_o),
        .result_o   (result_o),
        .flags_o    (flags_o)
    );

    // ====================
    // Clock and timeout
    // ====================
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            abortRun($sformatf("Timeout, run still busy after %0d cycles", TimeoutCycles));
        end
    end

    // ====================
    // Stimulus helpers
    // ====================

    // Next n LFSR bits with the newest in bit 0
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = galoisStep(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // Normal operand with exponent in [expLo, expLo + expSpan)
    function automatic fp32T randomOperand(input int expLo, input int expSpan);
        fp32T        op;
        logic [31:0] bits;
        bits     = takeBits(1);
        op.sign  = bits[0];
        bits     = takeBits(8);
        op.exp   = 8'(expLo + int'(bits) % expSpan);
        bits     = takeBits(23);
        op.frac  = bits[22:0];
        return op;
    endfunction

    // One strobe with its expected outcome and due cycle queued
    task automatic sendPair(input string name, input fp32T a, input fp32T b);
        fp32T    expR;
        fpFlagsT expF;
        @(negedge clk);
        expR      = fpMulRef(a, b, expF);
        opA_i     = a;
        opB_i     = b;
        inValid_i = 1'b1;
        nameQ.push_back(name);
        expResultQ.push_back(expR);
        expFlagsQ.push_back(expF);
        dueQ.push_back(cycleCount + Latency);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            inValid_i = 1'b0;
        end
    endtask

    task automatic sendGapped(input string tag);
        logic [31:0] gap;
        for (int i = 0; i < NumGap; i++) begin
            sendPair($sformatf("%s %0d", tag, i), randomOperand(64, 127),
                     randomOperand(64, 127));
            gap = takeBits(2);
            idleCycles(int'(gap));
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        arstN_i   = 1'b0;
        inValid_i = 1'b0;
        opA_i     = '0;
        opB_i     = '0;
        lfsrState = 32'hfdf8;
        repeat (ResetCycles) @(negedge clk);
        arstN_i = 1'b1;

        // Back-to-back random products
        for (int i = 0; i < NumRandom; i++) begin
            sendPair($sformatf("random %0d", i), randomOperand(64, 127),
                     randomOperand(64, 127));
        end

        // Rounding edge cases
        sendPair("tie odd rounds up", 32'h3F80_0001, 32'h3FC0_0000);
        sendPair("tie even stays", 32'h3F80_0003, 32'h3FC0_0000);
        sendPair("above half", 32'h3F80_0001, 32'h3FC0_0001);
        sendPair("carry into exponent", 32'h3FFF_FFFE, 32'h3F80_0001);
        sendPair("exact no shift", 32'h3FC0_0000, 32'h3FC0_0000);

        // Every pairing of the special values
        for (int i = 0; i < NumSpecialVals; i++) begin
            for (int j = 0; j < NumSpecialVals; j++) begin
                sendPair($sformatf("special %h x %h", SpecialVals[i], SpecialVals[j]),
                         fp32T'(SpecialVals[i]), fp32T'(SpecialVals[j]));
            end
        end

        // Exponent sums past both ends of the range
        for (int i = 0; i < NumRange; i++) begin
            sendPair($sformatf("overflow %0d", i), randomOperand(192, 63),
                     randomOperand(192, 63));
        end
        for (int i = 0; i < NumRange; i++) begin
            sendPair($sformatf("underflow %0d", i), randomOperand(1, 60),
                     randomOperand(1, 60));
        end

        // Random gaps, then a reset with items still in flight
        sendGapped("gapped");
        for (int i = 0; i < NumFlush; i++) begin
            sendPair($sformatf("flushed %0d", i), randomOperand(64, 127),
                     randomOperand(64, 127));
        end
        @(negedge clk);
        inValid_i = 1'b0;
        arstN_i   = 1'b0;
        nameQ.delete();
        expResultQ.delete();
        expFlagsQ.delete();
        dueQ.delete();
        repeat (MidResetCycles) @(negedge clk);
        arstN_i = 1'b1;
        sendGapped("after reset");

        // Drain past the last due cycle and watch for stray strobes
        idleCycles(Latency + 2);
        if (nameQ.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abortRun("Items still waiting for an output at the end of the run");
        end
    end

    // ====================
    // Output checker
    // ====================
    initial begin : checkLoop
        bit rstSeen;
        rstSeen = 1'b0;
        forever begin
            @(negedge clk);
            if (!arstN_i) begin
                // Skip the edge on which reset was just applied
                if (rstSeen && (outValid_o !== 1'b0)) begin
                    abortRun("outValid_o is not low while reset is held");
                end
                rstSeen = 1'b1;
            end else begin
                rstSeen = 1'b0;
                if (outValid_o === 1'b1) begin
                    if (nameQ.size() == 0) begin
                        abortRun("outValid_o strobed with no item in flight");
                    end else if (dueQ[0] != cycleCount) begin
                        abortRun($sformatf("Output for %s came at cycle %0d, due at cycle %0d",
                                           nameQ[0], cycleCount, dueQ[0]));
                    end else begin
                        compareResult(nameQ[0], expResultQ[0], result_o);
                        compareFlags(nameQ[0], expFlagsQ[0], flags_o);
                        void'(nameQ.pop_front());
                        void'(expResultQ.pop_front());
                        void'(expFlagsQ.pop_front());
                        void'(dueQ.pop_front());
                    end
                end else if (outValid_o !== 1'b0) begin
                    abortRun("outValid_o is unknown after reset");
                end else if ((nameQ.size() != 0) && (dueQ[0] <= cycleCount)) begin
                    abortRun($sformatf("No output for %s at its due cycle %0d",
                                       nameQ[0], dueQ[0]));
                end
            end
        end
    end

endmodule

// File: sim.f
+incdir+tb
design/fpFormatPkg.sv
design/fpMulPipePkg.sv
design/fpOperandDecode.sv
design/koaCombMult.sv
design/koaSignificandMult.sv
design/fpResultPack.sv
design/fpMulCore.sv
tb/fpMulCoreTb.sv

// File: Bender.yml
package:
  name: fp_mul_core

sources:
  - files:
      - design/fpFormatPkg.sv
      - design/fpMulPipePkg.sv
      - design/fpOperandDecode.sv
      - design/koaCombMult.sv
      - design/koaSignificandMult.sv
      - design/fpResultPack.sv
      - design/fpMulCore.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/fpMulCoreTb.sv
